//--- rtl/lmkbd_consts.svh
// lmkbd build constants
`ifndef LMKBD_CONSTS_SVH
`define LMKBD_CONSTS_SVH

// Queue holds 2**N key events
`define LMKBD_FIFO_DEPTH_LOG2 4

// System clocks with no PS/2 clock edge before a partial frame is dropped
`define LMKBD_RX_TIMEOUT 4000

// Flip-flops per PS/2 line synchronizer
`define LMKBD_SYNC_STAGES 2

`endif

//--- rtl/lmkbd_pkg.sv
// lmkbd shared types
package lmkbd_pkg;

  // One key event, as queued for the host
  typedef struct packed {
    logic       up;    // Set on key release
    logic [7:0] code;  // Lisp Machine key code
  } lm_key_event_t;

  // Prefix tracking in the control block
  typedef enum logic [2:0] {
    ST_IDLE,       // No prefix seen
    ST_EXT,        // After E0
    ST_BREAK,      // After F0
    ST_EXT_BREAK,  // After E0 and F0, either order
    ST_LOOKUP      // ROM address valid, result pending
  } lmkbd_state_t;

  // Classes of received PS/2 bytes
  typedef enum logic [1:0] {
    KIND_EXT,    // E0
    KIND_BREAK,  // F0
    KIND_E1,     // Pause prefix
    KIND_CODE    // Anything else
  } ps2_byte_kind_t;

endpackage

//--- rtl/ps2_rx.sv
// PS/2 frame receiver
`timescale 1ns/1ps
`include "lmkbd_consts.svh"

module ps2_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [7:0] rx_byte,
  output logic       rx_strobe,
  output logic       rx_error
);

  localparam int SYNC_STAGES = `LMKBD_SYNC_STAGES;
  localparam int TIMEOUT     = `LMKBD_RX_TIMEOUT;
  localparam int TO_W        = $clog2(TIMEOUT + 1);

  logic [SYNC_STAGES-1:0] clk_sync;
  logic [SYNC_STAGES-1:0] data_sync;
  logic                   clk_prev;   // Synchronized clock, one cycle back
  logic                   clk_fall;
  logic                   data_bit;
  logic [3:0]             bit_cnt;    // Bits taken in this frame
  logic [9:0]             shift_q;    // Start, data, parity; LSB first
  logic [10:0]            frame;
  logic                   frame_ok;
  logic [TO_W-1:0]        idle_cnt;

  // Both lines idle high
  always_ff @(posedge clk) begin
    if (rst) begin
      clk_sync  <= '1;
      data_sync <= '1;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
      data_sync <= {data_sync[SYNC_STAGES-2:0], ps2_data};
      clk_prev  <= clk_sync[SYNC_STAGES-1];
    end
  end

  assign clk_fall = clk_prev & ~clk_sync[SYNC_STAGES-1];
  assign data_bit = data_sync[SYNC_STAGES-1];

  // Full frame as of the stop-bit edge
  assign frame    = {data_bit, shift_q};
  assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]); // Start 0, stop 1, odd parity

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt   <= '0;
      idle_cnt  <= '0;
      rx_strobe <= 1'b0;
      rx_error  <= 1'b0;
    end else begin
      rx_strobe <= 1'b0;
      rx_error  <= 1'b0;
      if (clk_fall) begin
        idle_cnt <= '0;
        if (bit_cnt == 4'd10) begin // Stop bit
          bit_cnt   <= '0;
          rx_strobe <= frame_ok;
          rx_error  <= ~frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else if (bit_cnt != 4'd0) begin
        if (idle_cnt == TO_W'(TIMEOUT - 1)) begin // Keyboard went quiet mid-frame
          bit_cnt  <= '0;
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + TO_W'(1);
        end
      end
    end
  end

  // Frame bits and received byte
  always_ff @(posedge clk) begin
    if (clk_fall) begin
      shift_q <= {data_bit, shift_q[9:1]};
      if (bit_cnt == 4'd10) begin
        rx_byte <= frame[8:1];
      end
    end
  end

endmodule

//--- rtl/scancode_rom.sv
// PS/2 to Lisp Machine key map
`timescale 1ns/1ps

module scancode_rom (
  input  logic [8:0] addr,  // Bit 8 set for E0 codes
  output logic [7:0] data
);

  // Special keys
  localparam logic [7:0] LM_K_BREAK        = 8'o167;
  localparam logic [7:0] LM_K_CLEAR_INPUT  = 8'o110;
  localparam logic [7:0] LM_K_CALL         = 8'o107;
  localparam logic [7:0] LM_K_TERMINAL     = 8'o040;
  localparam logic [7:0] LM_K_HELP         = 8'o116;
  localparam logic [7:0] LM_K_RUBOUT       = 8'o023;
  localparam logic [7:0] LM_K_OVERSTRIKE   = 8'o160;
  localparam logic [7:0] LM_K_TAB          = 8'o022;
  localparam logic [7:0] LM_K_CLEAR_SCREEN = 8'o050;
  localparam logic [7:0] LM_K_RETURN       = 8'o136;
  localparam logic [7:0] LM_K_ABORT        = 8'o067;
  localparam logic [7:0] LM_K_RESUME       = 8'o047;
  localparam logic [7:0] LM_K_END          = 8'o156;
  localparam logic [7:0] LM_K_HAND_UP      = 8'o106;
  localparam logic [7:0] LM_K_HAND_DOWN    = 8'o176;
  localparam logic [7:0] LM_K_HAND_LEFT    = 8'o117;
  localparam logic [7:0] LM_K_HAND_RIGHT   = 8'o017;
  localparam logic [7:0] LM_K_SYSTEM       = 8'o141;
  localparam logic [7:0] LM_K_NETWORK      = 8'o042;

  // Shift keys
  localparam logic [7:0] LM_SH_LEFT_SHIFT    = 8'o024;
  localparam logic [7:0] LM_SH_RIGHT_SHIFT   = 8'o025;
  localparam logic [7:0] LM_SH_LEFT_TOP      = 8'o104;
  localparam logic [7:0] LM_SH_RIGHT_TOP     = 8'o155;
  localparam logic [7:0] LM_SH_LEFT_CONTROL  = 8'o020;
  localparam logic [7:0] LM_SH_RIGHT_CONTROL = 8'o026;
  localparam logic [7:0] LM_SH_LEFT_META     = 8'o045;
  localparam logic [7:0] LM_SH_RIGHT_META    = 8'o165;
  localparam logic [7:0] LM_SH_CAPSLOCK      = 8'o125;

  always_comb begin
    case (addr)
      9'h012: data = LM_SH_LEFT_SHIFT;
      9'h059: data = LM_SH_RIGHT_SHIFT;
      9'h11f: data = LM_SH_LEFT_TOP;      // Left GUI
      9'h127: data = LM_SH_RIGHT_TOP;     // Right GUI
      9'h014: data = LM_SH_LEFT_CONTROL;
      9'h114: data = LM_SH_RIGHT_CONTROL;
      9'h011: data = LM_SH_LEFT_META;     // Left Alt
      9'h111: data = LM_SH_RIGHT_META;    // Right Alt
      9'h058: data = LM_SH_CAPSLOCK;
      9'h005: data = LM_K_TERMINAL;       // F1
      9'h006: data = LM_K_SYSTEM;         // F2
      9'h004: data = LM_K_NETWORK;        // F3
      9'h00c: data = LM_K_ABORT;          // F4
      9'h003: data = LM_K_CLEAR_INPUT;    // F5
      9'h00b: data = LM_K_HELP;           // F6
      9'h083: data = LM_K_CLEAR_SCREEN;   // F7
      9'h007: data = LM_K_BREAK;          // F12
      9'h16c: data = LM_K_CALL;           // Home
      9'h169: data = LM_K_END;
      9'h17d: data = LM_K_BREAK;          // Page Up
      9'h17a: data = LM_K_RESUME;         // Page Down
      9'h170: data = LM_K_ABORT;          // Insert
      9'h171: data = LM_K_OVERSTRIKE;     // Delete
      9'h076: data = LM_K_TERMINAL;       // Esc
      9'h175: data = LM_K_HAND_UP;        // Arrow keys
      9'h172: data = LM_K_HAND_DOWN;
      9'h16b: data = LM_K_HAND_LEFT;
      9'h174: data = LM_K_HAND_RIGHT;
      9'h066: data = LM_K_RUBOUT;         // Backspace
      9'h05a: data = LM_K_RETURN;         // Enter
      9'h00d: data = LM_K_TAB;
      9'h01c: data = 8'o123;              // Letters A to Z
      9'h032: data = 8'o114;
      9'h021: data = 8'o164;
      9'h023: data = 8'o163;
      9'h024: data = 8'o162;
      9'h02b: data = 8'o013;
      9'h034: data = 8'o113;
      9'h033: data = 8'o053;
      9'h043: data = 8'o032;
      9'h03b: data = 8'o153;
      9'h042: data = 8'o033;
      9'h04b: data = 8'o073;
      9'h03a: data = 8'o154;
      9'h031: data = 8'o054;
      9'h044: data = 8'o072;
      9'h04d: data = 8'o172;
      9'h015: data = 8'o122;
      9'h02d: data = 8'o012;
      9'h01b: data = 8'o063;
      9'h02c: data = 8'o112;
      9'h03c: data = 8'o152;
      9'h02a: data = 8'o014;
      9'h01d: data = 8'o062;
      9'h022: data = 8'o064;
      9'h035: data = 8'o052;
      9'h01a: data = 8'o124;
      9'h045: data = 8'o171;              // Digits 0 to 9
      9'h016: data = 8'o121;
      9'h01e: data = 8'o061;
      9'h026: data = 8'o161;
      9'h025: data = 8'o011;
      9'h02e: data = 8'o111;
      9'h036: data = 8'o051;
      9'h03d: data = 8'o151;
      9'h03e: data = 8'o031;
      9'h046: data = 8'o071;
      9'h00e: data = 8'o077;              // Grave accent
      9'h04e: data = 8'o131;              // Minus
      9'h055: data = 8'o126;              // Equals
      9'h05d: data = 8'o037;              // Backslash
      9'h054: data = 8'o132;              // Left bracket
      9'h05b: data = 8'o137;              // Right bracket
      9'h04c: data = 8'o173;              // Semicolon
      9'h052: data = 8'o133;              // Apostrophe
      9'h041: data = 8'o034;              // Comma
      9'h049: data = 8'o074;              // Period
      9'h04a: data = 8'o174;              // Slash
      9'h029: data = 8'o134;              // Space
      default: data = 8'o000;             // Unmapped, dropped upstream
    endcase
  end

endmodule

//--- rtl/lmkbd_ctrl.sv
// Scancode prefix state machine
`timescale 1ns/1ps

module lmkbd_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [7:0]               rx_byte,
  input  logic                     rx_strobe,
  output logic [8:0]               rom_addr,
  input  logic [7:0]               rom_data,
  output logic                     push,
  output lmkbd_pkg::lm_key_event_t push_event
);

  import lmkbd_pkg::*;

  lmkbd_state_t   state;
  ps2_byte_kind_t kind;
  logic           ext_seen;
  logic           brk_seen;
  logic           code_in;
  logic           up_q;      // Release flag for the pending lookup

  always_comb begin
    case (rx_byte)
      8'he0:   kind = KIND_EXT;
      8'hf0:   kind = KIND_BREAK;
      8'he1:   kind = KIND_E1;
      default: kind = KIND_CODE;
    endcase
  end

  assign ext_seen = (state == ST_EXT) || (state == ST_EXT_BREAK);
  assign brk_seen = (state == ST_BREAK) || (state == ST_EXT_BREAK);
  assign code_in  = rx_strobe && (kind == KIND_CODE) && (state != ST_LOOKUP);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      push  <= 1'b0;
    end else begin
      push <= 1'b0;
      case (state)
        ST_LOOKUP: begin
          push  <= (rom_data != 8'h00); // Code zero means unmapped
          state <= ST_IDLE;
        end
        ST_IDLE, ST_EXT, ST_BREAK, ST_EXT_BREAK: begin
          if (rx_strobe) begin
            case (kind)
              KIND_EXT:   state <= brk_seen ? ST_EXT_BREAK : ST_EXT;
              KIND_BREAK: state <= ext_seen ? ST_EXT_BREAK : ST_BREAK;
              KIND_E1:    state <= ST_IDLE;  // Pause sequence, forget prefixes
              KIND_CODE:  state <= ST_LOOKUP;
              default:    state <= ST_IDLE;
            endcase
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ROM address and event fields
  always_ff @(posedge clk) begin
    if (code_in) begin
      rom_addr <= {ext_seen, rx_byte};
      up_q     <= brk_seen;
    end
    if (state == ST_LOOKUP) begin
      push_event.up   <= up_q;
      push_event.code <= rom_data;
    end
  end

endmodule

//--- rtl/key_event_fifo.sv
// Key event queue
`timescale 1ns/1ps

module key_event_fifo #(
  parameter int DEPTH_LOG2 = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     push,
  input  lmkbd_pkg::lm_key_event_t push_event,
  input  logic                     pop,
  output lmkbd_pkg::lm_key_event_t ev,
  output logic                     ev_valid,
  output logic                     overflow
);

  import lmkbd_pkg::*;

  localparam int DEPTH = 1 << DEPTH_LOG2;

  lm_key_event_t         mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  assign full     = count[DEPTH_LOG2];         // Count reaches DEPTH only when full
  assign do_pop   = pop && (count != '0);      // Pop on empty is ignored
  assign do_push  = push && (!full || do_pop); // Full queue still takes push with pop
  assign ev       = mem[rd_ptr];
  assign ev_valid = (count != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= push && full && !do_pop; // Incoming event lost
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_event;
    end
  end

endmodule

//--- rtl/lmkbd_top.sv
// PS/2 to Lisp Machine keyboard top
`timescale 1ns/1ps
`include "lmkbd_consts.svh"

module lmkbd_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ps2_clk,   // Asynchronous
  input  logic                     ps2_data,  // Asynchronous
  input  logic                     pop,
  output lmkbd_pkg::lm_key_event_t ev,
  output logic                     ev_valid,
  output logic                     rx_error,
  output logic                     overflow
);

  import lmkbd_pkg::*;

  logic [7:0]    rx_byte;
  logic          rx_strobe;
  logic [8:0]    rom_addr;
  logic [7:0]    rom_data;
  logic          push;
  lm_key_event_t push_event;

  ps2_rx i_rx (
    .clk       (clk),
    .rst       (rst),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe),
    .rx_error  (rx_error)
  );

  lmkbd_ctrl i_ctrl (
    .clk        (clk),
    .rst        (rst),
    .rx_byte    (rx_byte),
    .rx_strobe  (rx_strobe),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data),
    .push       (push),
    .push_event (push_event)
  );

  scancode_rom i_rom (
    .addr (rom_addr),
    .data (rom_data)
  );

  key_event_fifo #(
    .DEPTH_LOG2 (`LMKBD_FIFO_DEPTH_LOG2)
  ) i_fifo (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .push_event (push_event),
    .pop        (pop),
    .ev         (ev),
    .ev_valid   (ev_valid),
    .overflow   (overflow)
  );

endmodule

//--- verification/lmkbd_clk_gen.sv
// Testbench clock source
`timescale 1ns/1ps

module lmkbd_clk_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;  // 50 percent duty

endmodule

//--- verification/lmkbd_props.sv
// lmkbd port assertions
`timescale 1ns/1ps

module lmkbd_props (
  input logic                     clk,
  input logic                     rst,
  input logic                     pop,
  input lmkbd_pkg::lm_key_event_t ev,
  input logic                     ev_valid,
  input logic                     rx_error,
  input logic                     overflow
);

  // Queue comes out of reset empty
  a_valid_after_reset: assert property (@(posedge clk) rst |=> !ev_valid)
    else $error("ev_valid high right after reset");

  a_rx_error_pulse: assert property (@(posedge clk) disable iff (rst)
    rx_error |=> !rx_error)
    else $error("rx_error held for two cycles");

  a_overflow_pulse: assert property (@(posedge clk) disable iff (rst)
    overflow |=> !overflow)
    else $error("overflow held for two cycles");

  // Head of queue holds until popped
  a_head_stable: assert property (@(posedge clk) disable iff (rst)
    (ev_valid && !pop) |=> $stable(ev))
    else $error("ev changed without a pop");

endmodule

//--- verification/lmkbd_tb.sv
// lmkbd testbench
`timescale 1ns/1ps
`include "lmkbd_consts.svh"

module lmkbd_tb;

  import lmkbd_pkg::*;

  localparam int MAX_TESTS = 64;
  localparam int HALF_BIT  = 8;             // System clocks per PS/2 half period
  localparam int BYTE_CLKS = 11 * 17 + 48;  // One frame plus the longest gap
  localparam int DEPTH     = 1 << `LMKBD_FIFO_DEPTH_LOG2;
  localparam int K_PARITY  = 1;
  localparam int K_BURST   = 2;

  logic          clk;
  logic          rst;
  logic          ps2_clk;
  logic          ps2_data;
  logic          pop;
  lm_key_event_t ev;
  logic          ev_valid;
  logic          rx_error;
  logic          overflow;

  int   t_kind [MAX_TESTS];
  int   t_nb   [MAX_TESTS];
  int   t_b    [MAX_TESTS][4];
  int   t_ev   [MAX_TESTS];
  int   t_up   [MAX_TESTS];
  int   t_code [MAX_TESTS];
  int   n_tests;
  int   seed;
  int   err_total;
  int   ovf_total;
  int   limit;
  logic limit_ready;

  lmkbd_clk_gen #(.PERIOD_NS(20)) i_clk_gen (.clk(clk));

  lmkbd_top i_dut (
    .clk      (clk),
    .rst      (rst),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .pop      (pop),
    .ev       (ev),
    .ev_valid (ev_valid),
    .rx_error (rx_error),
    .overflow (overflow)
  );

  bind lmkbd_top lmkbd_props i_props (
    .clk      (clk),
    .rst      (rst),
    .pop      (pop),
    .ev       (ev),
    .ev_valid (ev_valid),
    .rx_error (rx_error),
    .overflow (overflow)
  );

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_event(input string name, input lm_key_event_t got,
                             input lm_key_event_t exp);
    if (got !== exp) begin
      report_fail($sformatf("ERROR %s got up=%h code=%h expected up=%h code=%h",
                            name, got.up, got.code, exp.up, exp.code));
    end
  endtask

  task automatic check_pulse(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_fail($sformatf("ERROR %s got %h expected %h", name, got, exp));
    end
  endtask

  function automatic ps2_byte_kind_t byte_kind(input logic [7:0] b);
    case (b)
      8'he0:   return KIND_EXT;
      8'hf0:   return KIND_BREAK;
      8'he1:   return KIND_E1;
      default: return KIND_CODE;
    endcase
  endfunction

  // Device to host frame, data sampled on falling PS/2 clock
  task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};  // Stop, parity, data, start
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      #2 ps2_data = bits[i];
      repeat (HALF_BIT) @(posedge clk);
      #2 ps2_clk = 1'b0;
      repeat (HALF_BIT) @(posedge clk);
      #2 ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic wait_event();
    int n;
    n = 0;
    while (!ev_valid) begin
      if (n >= 500) report_fail("No key event appeared in time");
      wait_clocks(1);
      n++;
    end
  endtask

  task automatic pop_event();
    pop = 1'b1;
    wait_clocks(1);
    pop = 1'b0;
  endtask

  task automatic load_tests();
    int    fd;
    int    r;
    int    v [9];
    string line;
    fd = $fopen("verification/lmkbd_tests.txt", "r");
    if (fd == 0) report_fail("Could not open verification/lmkbd_tests.txt");
    n_tests = 0;
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      r = $fgets(line, fd);
      if (r > 0 && line.getc(0) != "#") begin
        r = $sscanf(line, "%d %d %h %h %h %h %d %d %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
        if (r == 9) begin
          t_kind[n_tests] = v[0];
          t_nb[n_tests]   = v[1];
          for (int i = 0; i < 4; i++) t_b[n_tests][i] = v[2 + i];
          t_ev[n_tests]   = v[6];
          t_up[n_tests]   = v[7];
          t_code[n_tests] = v[8];
          n_tests++;
        end
      end
    end
    $fclose(fd);
    if (n_tests == 0) report_fail("Test file holds no tests");
  endtask

  task automatic run_test(input int t);
    int            err0;
    int            ovf0;
    int            gap;
    logic [7:0]    b;
    lm_key_event_t exp;
    err0     = err_total;
    ovf0     = ovf_total;
    exp.up   = t_up[t][0];
    exp.code = t_code[t][7:0];
    for (int i = 0; i < t_nb[t]; i++) begin
      b = (t_kind[t] == K_BURST) ? t_b[t][0][7:0] : t_b[t][i][7:0];
      $display("test %0d byte %h %s", t, b, byte_kind(b).name());
      send_frame(b, t_kind[t] == K_PARITY);
      gap = $unsigned($random(seed)) % 41;
      wait_clocks(gap);
    end
    wait_clocks(20);  // Lets the last event reach the queue
    check_pulse("rx_error", err_total != err0, t_kind[t] == K_PARITY);
    if (t_kind[t] == K_BURST) begin
      check_pulse("overflow", (ovf_total - ovf0) == 1, 1'b1);  // Exactly one lost
      for (int i = 0; i < DEPTH; i++) begin
        check_pulse("ev_valid", ev_valid, 1'b1);
        check_event("ev", ev, exp);
        pop_event();
      end
    end else begin
      check_pulse("overflow", ovf_total != ovf0, 1'b0);
      if (t_ev[t] != 0) begin
        wait_event();
        check_event("ev", ev, exp);
        pop_event();
      end
    end
    check_pulse("ev_valid", ev_valid, 1'b0);
  endtask

  // Pulse counters, sampled on the same edge the DUT uses
  always @(posedge clk) begin
    if (!rst) begin
      if (rx_error) err_total++;
      if (overflow) ovf_total++;
    end
  end

  initial begin
    rst         = 1'b1;
    ps2_clk     = 1'b1;
    ps2_data    = 1'b1;
    pop         = 1'b0;
    limit_ready = 1'b0;
    err_total   = 0;
    ovf_total   = 0;
    seed        = 32'h5264616f;
    load_tests();
    limit = 0;
    for (int t = 0; t < n_tests; t++) limit += t_nb[t] * BYTE_CLKS + 200;
    limit_ready = 1'b1;
    repeat (5) @(posedge clk);
    #2 rst = 1'b0;
    for (int t = 0; t < n_tests; t++) run_test(t);
    $display("All tests passed");
    $finish;
  end

  // Watchdog sized from the test list
  initial begin
    wait (limit_ready);
    repeat (limit + 10) @(posedge clk);
    report_fail("Watchdog expired before the tests finished");
  end

endmodule

//--- lmkbd.f
+incdir+rtl
rtl/lmkbd_pkg.sv
rtl/ps2_rx.sv
rtl/scancode_rom.sv
rtl/lmkbd_ctrl.sv
rtl/key_event_fifo.sv
rtl/lmkbd_top.sv
verification/lmkbd_clk_gen.sv
verification/lmkbd_props.sv
verification/lmkbd_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the lmkbd testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f lmkbd.f --top-module lmkbd_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vlmkbd_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- verification/lmkbd_tests.txt
# kind (0 good, 1 bad parity, 2 burst), byte count, bytes 0 to 3, event expected, up, code
# all bytes and codes in hex; a burst repeats byte 0 count times
0 1 1c 00 00 00 1 0 53
0 2 f0 1c 00 00 1 1 53
0 2 e0 75 00 00 1 0 46
0 3 e0 f0 14 00 1 1 16
0 3 f0 e0 14 00 1 1 16
0 2 e0 14 00 00 1 0 16
0 3 e0 f0 75 00 1 1 46
0 1 14 00 00 00 1 0 10
0 1 0a 00 00 00 0 0 00
0 1 1c 00 00 00 1 0 53
0 1 e1 00 00 00 0 0 00
0 1 83 00 00 00 1 0 28
1 1 1c 00 00 00 0 0 00
0 1 1c 00 00 00 1 0 53
2 17 1c 00 00 00 1 0 53
0 2 f0 1c 00 00 1 1 53
